// ==== source/txb_pkg.sv ====
//////////////////////////////////////////////////
// shared definitions for the tx dma buffer engine
// widths, request and completion records
// completion beat union and fsm state types
//////////////////////////////////////////////////
package txb_pkg;

    localparam int buf_aw   = 9;    // 512 qword buffer
    localparam int ptr_w    = 10;   // extra bit tells full from empty
    localparam int num_tags = 4;

    typedef logic [1:0]       tag_t;
    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [31:0]      qcount_t;

    typedef struct packed {
        logic [63:0] addr;      // host address of the page
        qcount_t     qwords;
    } page_desc_t;

    typedef struct packed {
        tag_t       tag;
        ptr_t       start;      // buffer slot of the first qword
        logic [9:0] size;       // qwords
    } rd_req_t;

    typedef struct packed {
        tag_t       tag;
        logic [9:0] qwords;     // written by one completion tlp
    } cpl_evt_t;

    // first beat of a completion, dw0 in the upper half
    typedef struct packed {
        logic        rsvd;
        logic [6:0]  fmt_type;
        logic [13:0] attr;
        logic [9:0]  length;    // dwords
        logic [15:0] cpl_id;
        logic [2:0]  status;
        logic        bcm;
        logic [11:0] byte_cnt;
    } cpl_hdr_t;

    typedef union packed {
        cpl_hdr_t         hdr;
        logic [1:0][31:0] dw;   // dw[1] is the earlier dword on the wire
    } beat_u;

    localparam logic [6:0] cpl_fmt_type = 7'b1001010;
    localparam logic [2:0] cpl_sc       = 3'b000;

    typedef enum logic [1:0] {rx_idle, rx_tag, rx_data, rx_skip} rx_state_e;
    typedef enum logic [1:0] {rq_idle, rq_check, rq_req, rq_wait} req_state_e;
    typedef enum logic [1:0] {nt_idle, nt_count, nt_notify} note_state_e;

endpackage

// ==== source/cpl_rx.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// completion receive path
// header filter for successful completions with data
// per-tag buffer pointer and carried tail dword
// dword realignment and buffer write port
//////////////////////////////////////////////////
module cpl_rx (
    input  logic                        trn_clk,
    input  logic                        reset_n,
    input  logic [63:0]                 trn_rd_i,
    input  logic                        trn_rsof_n_i,
    input  logic                        trn_reof_n_i,
    input  logic                        trn_rsrc_rdy_n_i,
    input  logic                        req_issue_i,
    input  txb_pkg::rd_req_t            req_i,
    output logic                        wr_en_o,
    output logic [txb_pkg::buf_aw-1:0]  wr_addr_o,
    output logic [63:0]                 wr_data_o,
    output logic                        cpl_done_o,
    output txb_pkg::cpl_evt_t           cpl_evt_o
);

    txb_pkg::beat_u               beat;
    txb_pkg::rx_state_e           state;
    txb_pkg::ptr_t                wptr [txb_pkg::num_tags];     // next slot per tag
    logic [31:0]                  saved_dw [txb_pkg::num_tags]; // odd tail per tag
    logic [txb_pkg::num_tags-1:0] saved_v;
    txb_pkg::tag_t                cur_tag;
    txb_pkg::tag_t                tag_sel;
    txb_pkg::ptr_t                cur_ptr;
    txb_pkg::ptr_t                ptr_in;
    txb_pkg::ptr_t                ptr_nxt;
    logic [31:0]                  pend;
    logic                         pend_v;
    logic [9:0]                   dw_left;   // payload dwords not yet seen
    logic [9:0]                   q_cnt;
    logic [9:0]                   q_nxt;
    logic [31:0]                  f_dw;
    logic [31:0]                  s_dw;
    logic                         s_v;
    logic [31:0]                  p_in;
    logic                         pv_in;
    logic [31:0]                  p_out;
    logic                         pv_out;
    logic                         do_wr;
    logic [63:0]                  wr_word;
    logic                         beat_v;
    logic                         eof;
    logic                         on_tag;
    logic                         take_pay;
    logic                         hdr_ok;

    function automatic logic [31:0] bswap(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    assign beat     = trn_rd_i;
    assign beat_v   = !trn_rsrc_rdy_n_i;
    assign eof      = !trn_reof_n_i;
    assign on_tag   = (state == txb_pkg::rx_tag);
    assign take_pay = beat_v && (on_tag || state == txb_pkg::rx_data);
    assign hdr_ok   = (beat.hdr.fmt_type == txb_pkg::cpl_fmt_type) &&
                      (beat.hdr.status == txb_pkg::cpl_sc);

    ////////////////////////////////////////////////
    // realignment, f_dw is earlier than s_dw
    ////////////////////////////////////////////////
    always_comb begin
        tag_sel = on_tag ? beat.dw[1][9:8] : cur_tag;   // tag in dw2
        s_dw    = bswap(beat.dw[0]);
        if (on_tag) begin
            f_dw   = s_dw;              // beat 2 has one payload dword
            s_v    = 1'b0;
            p_in   = saved_dw[tag_sel];
            pv_in  = saved_v[tag_sel];
            ptr_in = wptr[tag_sel];
        end else begin
            f_dw   = bswap(beat.dw[1]);
            s_v    = (dw_left >= 10'd2);
            p_in   = pend;
            pv_in  = pend_v;
            ptr_in = cur_ptr;
        end
        if (pv_in) begin                // carried dword fills the low half
            do_wr   = 1'b1;
            wr_word = {f_dw, p_in};
            p_out   = s_dw;
            pv_out  = s_v;
        end else begin
            do_wr   = s_v;
            wr_word = {s_dw, f_dw};
            p_out   = f_dw;
            pv_out  = !s_v;
        end
        ptr_nxt = do_wr ? ptr_in + 1'b1 : ptr_in;
        q_nxt   = (on_tag ? 10'd0 : q_cnt) + {9'd0, do_wr};
    end

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= txb_pkg::rx_idle;
            saved_v    <= '0;
            pend_v     <= 1'b0;
            wr_en_o    <= 1'b0;
            cpl_done_o <= 1'b0;
        end else begin
            wr_en_o    <= take_pay && do_wr;
            cpl_done_o <= take_pay && eof;
            if (req_issue_i) begin
                saved_v[req_i.tag] <= 1'b0;
            end
            if (take_pay) begin
                pend_v <= pv_out;
                state  <= eof ? txb_pkg::rx_idle : txb_pkg::rx_data;
                if (eof) begin
                    saved_v[tag_sel] <= pv_out;
                end
            end else if (beat_v) begin
                if (state == txb_pkg::rx_idle) begin
                    if (!trn_rsof_n_i && !eof) begin
                        state <= hdr_ok ? txb_pkg::rx_tag : txb_pkg::rx_skip;
                    end
                end else if (eof) begin     // end of a rejected tlp
                    state <= txb_pkg::rx_idle;
                end
            end
        end
    end

    always_ff @(posedge trn_clk) begin
        if (req_issue_i) begin
            wptr[req_i.tag] <= req_i.start;
        end
        if (beat_v && state == txb_pkg::rx_idle) begin
            dw_left <= beat.hdr.length;
        end
        if (take_pay) begin
            cur_tag   <= tag_sel;
            cur_ptr   <= ptr_nxt;
            pend      <= p_out;
            q_cnt     <= q_nxt;
            dw_left   <= dw_left - (on_tag ? 10'd1 : 10'd2);
            wr_addr_o <= ptr_in[txb_pkg::buf_aw-1:0];
            wr_data_o <= wr_word;
            if (eof) begin
                wptr[tag_sel]     <= ptr_nxt;
                saved_dw[tag_sel] <= p_out;
                cpl_evt_o.tag     <= tag_sel;
                cpl_evt_o.qwords  <= q_nxt;
            end
        end
    end

endmodule

// ==== source/rd_req_gen.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// read request generator
// walks one huge page in chunks
// buffer room and outstanding request checks
//////////////////////////////////////////////////
module rd_req_gen #(
    parameter int chunk_qwords = 32
) (
    input  logic                 trn_clk,
    input  logic                 reset_n,
    input  logic                 huge_page_status_i,
    input  txb_pkg::page_desc_t  huge_page_desc_i,
    output logic                 huge_page_free_o,
    output logic                 read_chunk_o,
    output logic [63:0]          huge_page_addr_read_from_o,
    output logic [9:0]           qwords_to_rd_o,
    input  txb_pkg::tag_t        tlp_tag_i,
    input  logic                 read_chunk_ack_i,
    input  txb_pkg::ptr_t        committed_rd_addr_i,
    input  logic                 commit_i,
    input  logic                 page_done_i,
    output logic                 req_issue_o,
    output txb_pkg::rd_req_t     req_o,
    output logic                 page_start_o,
    output txb_pkg::page_desc_t  page_desc_o
);

    localparam txb_pkg::ptr_t depth = txb_pkg::ptr_t'(1 << txb_pkg::buf_aw);

    txb_pkg::req_state_e state;
    txb_pkg::qcount_t    remain;       // page qwords not yet requested
    txb_pkg::ptr_t       nxt_wptr;
    txb_pkg::ptr_t       free_sp;
    logic [9:0]          chunk_sz;
    logic [2:0]          outstanding;
    logic                room;
    logic                acked;

    assign chunk_sz = (remain < txb_pkg::qcount_t'(chunk_qwords)) ? remain[9:0]
                                                                   : 10'(chunk_qwords);
    assign free_sp  = depth - (nxt_wptr - committed_rd_addr_i);
    assign room     = (free_sp >= chunk_sz) && (outstanding < 3'(txb_pkg::num_tags));
    assign acked    = read_chunk_o && read_chunk_ack_i;

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state                      <= txb_pkg::rq_idle;
            huge_page_free_o           <= 1'b0;
            read_chunk_o               <= 1'b0;
            req_issue_o                <= 1'b0;
            page_start_o               <= 1'b0;
            huge_page_addr_read_from_o <= '0;
            qwords_to_rd_o             <= '0;
            remain                     <= '0;
            nxt_wptr                   <= '0;
            outstanding                <= '0;
            req_o                      <= '0;
            page_desc_o                <= '0;
        end else begin
            huge_page_free_o <= 1'b0;
            req_issue_o      <= 1'b0;
            page_start_o     <= 1'b0;
            outstanding      <= outstanding + {2'b00, acked} - {2'b00, commit_i};
            case (state)
                txb_pkg::rq_idle: begin
                    if (huge_page_status_i) begin
                        page_start_o               <= 1'b1;
                        page_desc_o                <= huge_page_desc_i;
                        huge_page_addr_read_from_o <= huge_page_desc_i.addr;
                        remain                     <= huge_page_desc_i.qwords;
                        state                      <= txb_pkg::rq_check;
                    end
                end
                txb_pkg::rq_check: begin
                    if (room) begin
                        read_chunk_o   <= 1'b1;
                        qwords_to_rd_o <= chunk_sz;
                        state          <= txb_pkg::rq_req;
                    end
                end
                txb_pkg::rq_req: begin
                    if (read_chunk_ack_i) begin
                        read_chunk_o <= 1'b0;
                        req_issue_o  <= 1'b1;
                        req_o        <= '{tag: tlp_tag_i, start: nxt_wptr, size: qwords_to_rd_o};
                        nxt_wptr     <= nxt_wptr + qwords_to_rd_o;
                        huge_page_addr_read_from_o <= huge_page_addr_read_from_o +
                                                      64'({qwords_to_rd_o, 3'b000});
                        remain       <= remain - txb_pkg::qcount_t'(qwords_to_rd_o);
                        if (remain == txb_pkg::qcount_t'(qwords_to_rd_o)) begin
                            huge_page_free_o <= 1'b1;   // last chunk of the page
                            state            <= txb_pkg::rq_wait;
                        end else begin
                            state <= txb_pkg::rq_check;
                        end
                    end
                end
                default: begin
                    if (page_done_i) begin  // notification taken by host
                        state <= txb_pkg::rq_idle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/commit_tracker.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// in-order commit of buffer writes
// queue of issued requests and per-tag qword counts
// committed write pointer
//////////////////////////////////////////////////
module commit_tracker (
    input  logic               trn_clk,
    input  logic               reset_n,
    input  logic               req_issue_i,
    input  txb_pkg::rd_req_t   req_i,
    input  logic               cpl_done_i,
    input  txb_pkg::cpl_evt_t  cpl_evt_i,
    output txb_pkg::ptr_t      committed_wr_addr_o,
    output logic               commit_o,
    output logic [9:0]         commit_qwords_o
);

    txb_pkg::rd_req_t q [txb_pkg::num_tags];     // issue order
    logic [9:0]       rcvd [txb_pkg::num_tags];  // qwords landed per tag
    logic [1:0]       head;
    logic [1:0]       tail;
    logic [2:0]       used;
    txb_pkg::rd_req_t hd;
    logic             head_done;

    assign hd        = q[head];
    assign head_done = (used != 3'd0) && (rcvd[hd.tag] == hd.size);

    always_ff @(posedge trn_clk) begin
        if (req_issue_i) begin
            q[tail]         <= req_i;
            rcvd[req_i.tag] <= '0;
        end
        if (cpl_done_i) begin
            rcvd[cpl_evt_i.tag] <= rcvd[cpl_evt_i.tag] + cpl_evt_i.qwords;
        end
    end

    ////////////////////////////////////////////////
    // retire the oldest request once all its data is in
    ////////////////////////////////////////////////
    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            head                <= '0;
            tail                <= '0;
            used                <= '0;
            commit_o            <= 1'b0;
            commit_qwords_o     <= '0;
            committed_wr_addr_o <= '0;
        end else begin
            commit_o <= head_done;
            used     <= used + {2'b00, req_issue_i} - {2'b00, head_done};
            if (req_issue_i) begin
                tail <= tail + 1'b1;
            end
            if (head_done) begin
                head                <= head + 1'b1;
                committed_wr_addr_o <= hd.start + hd.size;
                commit_qwords_o     <= hd.size;
            end
        end
    end

endmodule

// ==== source/page_notifier.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// page completion notifier
// sums committed qwords and posts the page address
//////////////////////////////////////////////////
module page_notifier (
    input  logic                 trn_clk,
    input  logic                 reset_n,
    input  logic                 page_start_i,
    input  txb_pkg::page_desc_t  page_desc_i,
    input  logic                 commit_i,
    input  logic [9:0]           commit_qwords_i,
    output logic                 notify_o,
    output logic [63:0]          notification_message_o,
    input  logic                 notify_ack_i,
    output logic                 page_done_o
);

    txb_pkg::note_state_e state;
    txb_pkg::qcount_t     page_qwords;
    txb_pkg::qcount_t     sum;
    txb_pkg::qcount_t     sum_nxt;

    assign sum_nxt = sum + txb_pkg::qcount_t'(commit_qwords_i);

    always_ff @(posedge trn_clk or negedge reset_n) begin
        if (!reset_n) begin
            state                  <= txb_pkg::nt_idle;
            notify_o               <= 1'b0;
            page_done_o            <= 1'b0;
            notification_message_o <= '0;
            page_qwords            <= '0;
            sum                    <= '0;
        end else begin
            page_done_o <= 1'b0;
            case (state)
                txb_pkg::nt_idle: begin
                    if (page_start_i) begin
                        sum                    <= '0;
                        page_qwords            <= page_desc_i.qwords;
                        notification_message_o <= page_desc_i.addr;
                        state                  <= txb_pkg::nt_count;
                    end
                end
                txb_pkg::nt_count: begin
                    if (commit_i) begin
                        sum <= sum_nxt;
                        if (sum_nxt == page_qwords) begin   // whole page committed
                            notify_o <= 1'b1;
                            state    <= txb_pkg::nt_notify;
                        end
                    end
                end
                default: begin
                    if (notify_ack_i) begin
                        notify_o    <= 1'b0;
                        page_done_o <= 1'b1;
                        state       <= txb_pkg::nt_idle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== source/txb_top.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// tx dma buffer engine top level
// request generator, completion path,
// commit tracker and page notifier
//////////////////////////////////////////////////
module txb_top #(
    parameter int chunk_qwords = 32
) (
    input  logic                        trn_clk,
    input  logic                        reset_n,
    input  logic                        huge_page_status_i,
    input  txb_pkg::page_desc_t         huge_page_desc_i,
    output logic                        huge_page_free_o,
    output logic                        read_chunk_o,
    output logic [63:0]                 huge_page_addr_read_from_o,
    output logic [9:0]                  qwords_to_rd_o,
    input  txb_pkg::tag_t               tlp_tag_i,
    input  logic                        read_chunk_ack_i,
    input  logic [63:0]                 trn_rd_i,
    input  logic                        trn_rsof_n_i,
    input  logic                        trn_reof_n_i,
    input  logic                        trn_rsrc_rdy_n_i,
    output logic                        wr_en_o,
    output logic [txb_pkg::buf_aw-1:0]  wr_addr_o,
    output logic [63:0]                 wr_data_o,
    input  txb_pkg::ptr_t               committed_rd_addr_i,
    output txb_pkg::ptr_t               committed_wr_addr_o,
    output logic                        notify_o,
    output logic [63:0]                 notification_message_o,
    input  logic                        notify_ack_i
);

    logic                req_issue;
    txb_pkg::rd_req_t    req;
    logic                cpl_done;
    txb_pkg::cpl_evt_t   cpl_evt;
    logic                commit;
    logic [9:0]          commit_qwords;
    logic                page_start;
    txb_pkg::page_desc_t page_desc;
    logic                page_done;

    rd_req_gen #(.chunk_qwords(chunk_qwords)) rd_req_gen_i (
        .trn_clk, .reset_n, .huge_page_status_i, .huge_page_desc_i, .huge_page_free_o,
        .read_chunk_o, .huge_page_addr_read_from_o, .qwords_to_rd_o, .tlp_tag_i,
        .read_chunk_ack_i, .committed_rd_addr_i, .commit_i(commit), .page_done_i(page_done),
        .req_issue_o(req_issue), .req_o(req), .page_start_o(page_start),
        .page_desc_o(page_desc)
    );

    cpl_rx cpl_rx_i (
        .trn_clk, .reset_n, .trn_rd_i, .trn_rsof_n_i, .trn_reof_n_i, .trn_rsrc_rdy_n_i,
        .req_issue_i(req_issue), .req_i(req), .wr_en_o, .wr_addr_o, .wr_data_o,
        .cpl_done_o(cpl_done), .cpl_evt_o(cpl_evt)
    );

    commit_tracker commit_tracker_i (
        .trn_clk, .reset_n, .req_issue_i(req_issue), .req_i(req), .cpl_done_i(cpl_done),
        .cpl_evt_i(cpl_evt), .committed_wr_addr_o, .commit_o(commit),
        .commit_qwords_o(commit_qwords)
    );

    page_notifier page_notifier_i (
        .trn_clk, .reset_n, .page_start_i(page_start), .page_desc_i(page_desc),
        .commit_i(commit), .commit_qwords_i(commit_qwords), .notify_o,
        .notification_message_o, .notify_ack_i, .page_done_o(page_done)
    );

endmodule

// ==== include/tb_ref.svh ====
//////////////////////////////////////////////////
// testbench helpers for the tx dma buffer engine
// random number generator, host memory reference
// value check and failure report
//////////////////////////////////////////////////
`ifndef TB_REF_SVH
`define TB_REF_SVH

logic [31:0] rng_state = 32'h5dc1b5dc;

// lcg step, result below n
function automatic int unsigned rand_below(input int unsigned n);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 8) % n;
endfunction

// host memory contents, hash of the dword address
function automatic logic [31:0] host_dword(input logic [63:0] dw_addr);
    logic [31:0] h;
    h = dw_addr[31:0] ^ dw_addr[63:32];
    h = h * 32'h9e3779b1;
    h = h ^ (h >> 15);
    h = h * 32'h85ebca6b;
    h = h ^ (h >> 13);
    return h;
endfunction

function automatic logic [31:0] byte_rev(input logic [31:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
endfunction

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
        $display("** FAIL **");
        $fatal(1);
    end
endtask

task automatic report_failure(input string what);
    $display("[ERROR] %0t ns %s", $time, what);
    $display("** FAIL **");
    $fatal(1);
endtask

`endif

// ==== tb/tb_txb.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// testbench for the tx dma buffer engine
// host request and completion model, buffer model
// consumer, in-order commit and notification checks
//////////////////////////////////////////////////
module tb_txb;

    `include "tb_ref.svh"

    localparam int chunk_qwords = 32;
    localparam int num_pages    = 3;
    localparam int total_qwords = 201;

    logic                trn_clk;
    logic                reset_n;
    logic                huge_page_status_i;
    txb_pkg::page_desc_t huge_page_desc_i;
    logic                huge_page_free_o;
    logic                read_chunk_o;
    logic [63:0]         huge_page_addr_read_from_o;
    logic [9:0]          qwords_to_rd_o;
    txb_pkg::tag_t       tlp_tag_i;
    logic                read_chunk_ack_i;
    logic [63:0]         trn_rd_i;
    logic                trn_rsof_n_i;
    logic                trn_reof_n_i;
    logic                trn_rsrc_rdy_n_i;
    logic                wr_en_o;
    logic [8:0]          wr_addr_o;
    logic [63:0]         wr_data_o;
    txb_pkg::ptr_t       committed_rd_addr_i;
    txb_pkg::ptr_t       committed_wr_addr_o;
    logic                notify_o;
    logic [63:0]         notification_message_o;
    logic                notify_ack_i;

    logic [63:0] mem [512];     // buffer model
    logic [63:0] pg_addr [num_pages];
    int          pg_size [num_pages];
    int          pg, issued, committed_q, free_cnt, notes_done, wr_cnt, bad_cnt, n_out;
    int          ack_wait, note_wait;
    logic [9:0]  exp_wptr, last_cwp;
    logic        prev_rc, note_seen;
    logic [1:0]  next_tag;
    logic [9:0]  rq_start [$];  // issued requests, oldest first
    logic [9:0]  rq_size [$];
    logic [63:0] rq_dwa [$];
    logic [1:0]  pend_tag [$];  // completion tlps not yet sent
    logic [63:0] pend_dwa [$];
    int          pend_len [$];
    logic [63:0] bq_data [$];   // beats of the tlp on the wire
    logic        bq_sof [$];
    logic        bq_eof [$];

    txb_top #(.chunk_qwords(chunk_qwords)) dut_i (.*);

    initial begin
        trn_clk = 1'b0;
        forever #20 trn_clk = ~trn_clk;
    end

    initial begin
        #(longint'(total_qwords) * 200 * 40);
        report_failure("timeout, the engine stopped making progress");
    end

    // header, tag beat with first dword, then dword pairs
    task automatic build_tlp(input logic [1:0] tag, input logic [63:0] dwa, input int len,
                             input logic [6:0] fmt, input logic [2:0] status);
        int i;
        bq_data.push_back({1'b0, fmt, 14'd0, 10'(len), 16'd0, status, 13'd0});
        bq_sof.push_back(1'b1);
        bq_eof.push_back(1'b0);
        bq_data.push_back({22'd0, tag, 8'd0, byte_rev(host_dword(dwa))});
        bq_sof.push_back(1'b0);
        bq_eof.push_back(len == 1);
        for (i = 1; i < len; i += 2) begin
            bq_data.push_back({byte_rev(host_dword(dwa + i)),
                               (i + 1 < len) ? byte_rev(host_dword(dwa + i + 1)) : 32'd0});
            bq_sof.push_back(1'b0);
            bq_eof.push_back(i + 2 >= len);
        end
    endtask

    // split one request into 1 to 3 completions
    task automatic queue_request(input logic [1:0] tag, input logic [63:0] dwa, input int size);
        int total, n, k, l;
        total = 2 * size;
        n = 1 + rand_below(3);
        if (n > total) n = total;
        for (k = 0; k < n; k++) begin
            l = (k == n - 1) ? total : 1 + rand_below(total - (n - 1 - k));
            pend_tag.push_back(tag);
            pend_dwa.push_back(dwa);
            pend_len.push_back(l);
            dwa   += l;
            total -= l;
        end
    endtask

    task automatic send_beat();
        int i, j;
        if (bq_data.size() == 0) begin
            if (bad_cnt == 0 || (rand_below(12) == 0 && bad_cnt < 8)) begin
                if (bad_cnt[0]) build_tlp(2'd0, 64'd0, 3, txb_pkg::cpl_fmt_type, 3'b001);
                else build_tlp(2'd0, 64'd0, 3, 7'b0000000, txb_pkg::cpl_sc);
                bad_cnt++;
            end else if (pend_tag.size() != 0) begin
                i = rand_below(pend_tag.size());
                for (j = 0; pend_tag[j] != pend_tag[i]; j++) ;   // oldest tlp of that tag
                build_tlp(pend_tag[j], pend_dwa[j], pend_len[j], txb_pkg::cpl_fmt_type,
                          txb_pkg::cpl_sc);
                pend_tag.delete(j);
                pend_dwa.delete(j);
                pend_len.delete(j);
            end
        end
        if (bq_data.size() != 0 && rand_below(4) != 0) begin
            trn_rd_i         = bq_data.pop_front();
            trn_rsof_n_i     = !bq_sof.pop_front();
            trn_reof_n_i     = !bq_eof.pop_front();
            trn_rsrc_rdy_n_i = 1'b0;
        end else begin
            trn_rsrc_rdy_n_i = 1'b1;    // source gap
            trn_rsof_n_i     = 1'b1;
            trn_reof_n_i     = 1'b1;
        end
    endtask

    task automatic check_commit();
        int j;
        if (committed_wr_addr_o == last_cwp) return;
        if (rq_start.size() == 0) report_failure("committed pointer moved with no request open");
        check_val("committed_wr_addr_o", committed_wr_addr_o, rq_start[0] + rq_size[0]);
        for (j = 0; j < rq_size[0]; j++) begin
            check_val("buffer qword", mem[(rq_start[0] + j) % 512],
                      {host_dword(rq_dwa[0] + 2 * j + 1), host_dword(rq_dwa[0] + 2 * j)});
        end
        committed_q += rq_size[0];
        n_out--;
        last_cwp = committed_wr_addr_o;
        void'(rq_start.pop_front());
        void'(rq_size.pop_front());
        void'(rq_dwa.pop_front());
    endtask

    task automatic handle_request();
        logic [9:0] free_sp;
        int         exp_sz;
        if (read_chunk_ack_i) begin
            read_chunk_ack_i = 1'b0;
        end else if (read_chunk_o) begin
            if (!prev_rc) begin
                free_sp = 10'd512 - (exp_wptr - committed_rd_addr_i);
                check_val("outstanding requests below 4", n_out < 4, 1);
                check_val("qwords_to_rd_o within free space", qwords_to_rd_o <= free_sp, 1);
                ack_wait = rand_below(4);
            end
            if (ack_wait == 0) begin
                exp_sz = pg_size[pg] - issued;
                if (exp_sz > chunk_qwords) exp_sz = chunk_qwords;
                check_val("huge_page_addr_read_from_o", huge_page_addr_read_from_o,
                          pg_addr[pg] + 8 * issued);
                check_val("qwords_to_rd_o", qwords_to_rd_o, exp_sz);
                rq_start.push_back(exp_wptr);
                rq_size.push_back(qwords_to_rd_o);
                rq_dwa.push_back(huge_page_addr_read_from_o >> 2);
                queue_request(next_tag, huge_page_addr_read_from_o >> 2, qwords_to_rd_o);
                read_chunk_ack_i = 1'b1;
                tlp_tag_i        = next_tag;
                next_tag++;
                exp_wptr += qwords_to_rd_o;
                issued   += qwords_to_rd_o;
                n_out++;
            end else begin
                ack_wait--;
            end
        end
    endtask

    task automatic handle_notify();
        if (notify_ack_i) begin
            notify_ack_i = 1'b0;
            note_seen    = 1'b0;
            notes_done++;
            pg++;
            issued      = 0;
            committed_q = 0;
            free_cnt    = 0;
        end else if (notify_o) begin
            check_val("read_chunk_o while notify held", read_chunk_o, 0);
            if (!note_seen) begin
                check_val("notification_message_o", notification_message_o, pg_addr[pg]);
                check_val("committed qwords at notify", committed_q, pg_size[pg]);
                check_val("huge_page_free_o pulses", free_cnt, 1);
                note_seen = 1'b1;
                note_wait = rand_below(6);
            end
            if (note_wait == 0) notify_ack_i = 1'b1;
            else note_wait--;
        end
    endtask

    ////////////////////////////////////////////////
    // monitors and host side drivers, falling edge
    ////////////////////////////////////////////////
    initial begin
        @(posedge reset_n);
        forever @(negedge trn_clk) begin
            if (wr_en_o) begin
                mem[wr_addr_o] = wr_data_o;
                wr_cnt++;
            end
            if (huge_page_free_o) begin
                free_cnt++;
                check_val("issued qwords at huge_page_free_o", issued, pg_size[pg]);
            end
            check_commit();
            handle_notify();
            send_beat();    // completions of a request start after its ack cycle
            if (pg < num_pages) handle_request();
            prev_rc = read_chunk_o;
            if (committed_wr_addr_o != committed_rd_addr_i && rand_below(6) == 0) begin
                committed_rd_addr_i += 1 + rand_below(committed_wr_addr_o - committed_rd_addr_i);
            end
        end
    end

    initial begin
        pg_addr = '{64'h0000_0001_0000_0000, 64'h0000_0003_2000_0018, 64'h0000_000f_fff0_0100};
        pg_size = '{37, 100, 64};
        {pg, issued, committed_q, free_cnt, notes_done, wr_cnt, bad_cnt, n_out} = '0;
        {ack_wait, note_wait, exp_wptr, last_cwp, prev_rc, note_seen, next_tag} = '0;
        reset_n             = 1'b0;
        huge_page_status_i  = 1'b0;
        huge_page_desc_i    = '0;
        tlp_tag_i           = '0;
        read_chunk_ack_i    = 1'b0;
        trn_rd_i            = '0;
        trn_rsof_n_i        = 1'b1;
        trn_reof_n_i        = 1'b1;
        trn_rsrc_rdy_n_i    = 1'b1;
        committed_rd_addr_i = '0;
        notify_ack_i        = 1'b0;
        repeat (2) @(posedge trn_clk);
        @(negedge trn_clk);
        reset_n = 1'b1;
        for (int p = 0; p < num_pages; p++) begin
            @(negedge trn_clk);
            huge_page_status_i = 1'b1;
            huge_page_desc_i   = '{addr: pg_addr[p], qwords: pg_size[p]};
            do @(negedge trn_clk); while (!read_chunk_o);
            huge_page_status_i = 1'b0;
            wait (notify_o);    // next page offered while the notification waits for its ack
        end
        wait (notes_done == num_pages);
        repeat (2) @(negedge trn_clk);
        check_val("buffer writes", wr_cnt, total_qwords);
        check_val("open requests at end", rq_start.size(), 0);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
source/txb_pkg.sv
source/cpl_rx.sv
source/rd_req_gen.sv
source/commit_tracker.sv
source/page_notifier.sv
source/txb_top.sv
tb/tb_txb.sv
